// File: bank_htu.f
// bank hit-test unit, compile order
+incdir+bench

// package first, then leaf modules, then top
hdl/htu_pkg.sv
hdl/htu_req_decode.sv
hdl/htu_set_entry.sv
hdl/htu_resp_mux.sv
hdl/bank_htu.sv

// testbench
bench/tb_bank_htu.sv

// File: bench/htu_patterns.txt
// kind op ch_id addr wbuf | expected: linefill_valid way need_evict off0 off1
// kind 0 request, 1 fill done (addr gives set/offset, way column the way), 2 end
// read to empty cache, then repeat before fill
0 0 0 00001440 11 1 0 0 0 0
0 0 1 00001440 12 1 0 0 0 0
// fill offset 0, then both offsets
1 0 0 00001440 00 0 0 0 0 0
0 0 2 00001440 13 0 0 0 1 0
0 0 3 00001450 14 1 0 0 1 0
// write hit, then read back dirty
0 1 1 00001450 21 0 0 0 1 0
0 0 0 00001450 22 0 0 0 1 3
// more tags into set 2, ways 1 to 7
0 0 2 00001840 31 1 1 0 0 0
0 1 3 00001c50 32 0 2 0 0 0
0 0 0 00002040 33 1 3 0 0 0
0 0 1 00002450 34 1 4 0 0 0
0 1 2 a5a5a840 35 0 5 0 0 0
0 0 3 00002c40 36 1 6 0 0 0
0 0 0 fffffc40 37 1 7 0 0 0
// ninth tag wraps onto dirty way 0
0 0 1 00003440 38 1 0 1 1 3
// evicted tag comes back in way 1
0 0 2 00001440 41 1 1 0 0 0
0 0 3 00001c50 42 0 2 0 0 3
0 0 0 00001840 43 1 2 1 0 3
// set 5 is independent of set 2
0 0 1 000014a0 51 1 0 0 0 0
1 0 0 000014a0 00 0 0 0 0 0
0 0 2 00001440 52 1 1 0 0 0
0 0 3 000014a0 53 0 0 0 1 0
0 1 0 000014b0 54 0 0 0 1 0
0 0 1 000014b0 55 0 0 0 1 3
// end marker
2 0 0 00000000 00 0 0 0 0 0

// File: bench/htu_checks.svh
`ifndef HTU_CHECKS_SVH
`define HTU_CHECKS_SVH

// run bookkeeping
int err_count  = 0;
int fail_count = 0;
int test_count = 0;
int test_errs  = 0;
int cur_test   = 0;

logic [31:0] lfsr_state = 32'h7543_4ddb;

// galois lfsr for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h8020_0003;
  end
  return s >> 1;
endfunction

// one lfsr step per bit taken
task automatic rand_bits(input int n, output logic [31:0] v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    v = {v[30:0], lfsr_state[0]};
  end
endtask

task automatic note_mismatch();
  err_count++;
  test_errs++;
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[FAIL] test %0d %s: got %h expected %h", cur_test, name, got, exp);
    note_mismatch();
  end
endtask

task automatic check_isu_req(input string name, input htu_pkg::isu_req_t got,
                             input htu_pkg::isu_req_t exp);
  if (got !== exp) begin
    $display("[FAIL] test %0d %s: got %h expected %h", cur_test, name, got, exp);
    note_mismatch();
  end
endtask

task automatic check_linefill(input string name, input htu_pkg::linefill_t got,
                              input htu_pkg::linefill_t exp);
  if (got !== exp) begin
    $display("[FAIL] test %0d %s: got %h expected %h", cur_test, name, got, exp);
    note_mismatch();
  end
endtask

`endif

// File: bench/tb_bank_htu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bank_htu;

  localparam int CLK_PERIOD  = 20;
  localparam int DRV         = 2;
  localparam int SMP         = 16;
  localparam int REC_W       = 10;
  localparam int MAX_REC     = 64;
  localparam int READY_LIMIT = 50;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  xbar_valid;
  htu_pkg::htu_req_t     xbar_req;
  logic                  isu_allow;
  htu_pkg::fill_done_t   fill_done;
  logic                  xbar_ready;
  logic                  isu_valid;
  htu_pkg::isu_req_t     isu_req;
  logic                  linefill_valid;
  htu_pkg::linefill_t    linefill;

  logic [31:0] pat_mem [MAX_REC*REC_W];
  logic        timed_out = 1'b0;

  `include "htu_checks.svh"

  bank_htu dut0 (
    .clk_i            (clk           ),
    .rst_i            (rst           ),
    .xbar_valid_i     (xbar_valid    ),
    .xbar_req_i       (xbar_req      ),
    .xbar_ready_o     (xbar_ready    ),
    .isu_allow_i      (isu_allow     ),
    .isu_valid_o      (isu_valid     ),
    .isu_req_o        (isu_req       ),
    .linefill_valid_o (linefill_valid),
    .linefill_o       (linefill      ),
    .fill_done_i      (fill_done     )
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // ------------------------------------------------------------
  // per-test helpers
  // ------------------------------------------------------------
  task automatic finish_test(input string what);
    test_count++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", cur_test, what);
    end else begin
      fail_count++;
      $display("test %0d %s: %0d mismatches", cur_test, what, test_errs);
    end
  endtask

  // enters and leaves at a sample point
  task automatic wait_ready();
    int n;
    n = 0;
    while (xbar_ready !== 1'b1 && !timed_out) begin
      n++;
      if (n > READY_LIMIT) begin
        $display("timeout: xbar_ready_o never went high in test %0d", cur_test);
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        #(DRV + SMP);
      end
    end
  endtask

  task automatic check_outputs(input htu_pkg::isu_req_t exp_isu, input logic exp_lfv,
                               input htu_pkg::linefill_t exp_lf, input logic exp_ready);
    check_bit("xbar_ready_o", xbar_ready, exp_ready);
    check_bit("isu_valid_o", isu_valid, 1'b1);
    check_bit("linefill_valid_o", linefill_valid, exp_lfv);
    check_isu_req("isu_req_o", isu_req, exp_isu);
    if (exp_lfv) begin
      check_linefill("linefill_o", linefill, exp_lf);
    end
  endtask

  task automatic run_request(input int base);
    htu_pkg::htu_req_t  req;
    htu_pkg::isu_req_t  exp_isu;
    htu_pkg::linefill_t exp_lf;
    logic               exp_lfv;
    logic [31:0]        addr;
    logic [31:0]        rnd;
    int                 stalls;
    addr           = pat_mem[base+3];
    req.ch_id      = pat_mem[base+2][1:0];
    req.opcode     = pat_mem[base+1][1:0];
    req.addr       = addr[31:htu_pkg::ADDR_LO];
    req.wbuffer_id = pat_mem[base+4][7:0];
    // index sits just above the offset bit
    exp_lfv    = pat_mem[base+5][0];
    exp_lf.set = addr[htu_pkg::ADDR_LO+htu_pkg::SET_W:htu_pkg::ADDR_LO+1];
    exp_lf.way = pat_mem[base+6][2:0];
    exp_isu.ch_id          = req.ch_id;
    exp_isu.opcode         = {pat_mem[base+7][0], req.opcode == htu_pkg::OP_WRITE};
    exp_isu.set_way_offset = {exp_lf.set, exp_lf.way, addr[htu_pkg::ADDR_LO]};
    exp_isu.wbuffer_id     = req.wbuffer_id;
    exp_isu.off0_state     = pat_mem[base+8][1:0];
    exp_isu.off1_state     = pat_mem[base+9][1:0];

    rand_bits(2, rnd);
    stalls = rnd & 32'h3;
    @(posedge clk);
    #DRV;
    xbar_valid = 1'b1;
    xbar_req   = req;
    isu_allow  = (stalls == 0);
    // outputs repeat under back-pressure and nothing commits
    for (int s = 0; s < stalls; s++) begin
      #SMP;
      check_outputs(exp_isu, exp_lfv, exp_lf, 1'b0);
      @(posedge clk);
      #DRV;
      if (s == stalls - 1) begin
        isu_allow = 1'b1;
      end
    end
    #SMP;
    check_outputs(exp_isu, exp_lfv, exp_lf, 1'b1);
    wait_ready();
    if (!timed_out) begin
      @(posedge clk);
      #DRV;
      xbar_valid = 1'b0;
      isu_allow  = 1'b0;
      #SMP;
      check_bit("isu_valid_o", isu_valid, 1'b0);
      check_bit("linefill_valid_o", linefill_valid, 1'b0);
    end
    finish_test($sformatf("%s addr %h stalls %0d", (req.opcode == htu_pkg::OP_WRITE) ?
                          "write" : "read", addr, stalls));
  endtask

  task automatic run_fill(input int base);
    logic [31:0] addr;
    logic [2:0]  way;
    addr = pat_mem[base+3];
    way  = pat_mem[base+6][2:0];
    @(posedge clk);
    #DRV;
    fill_done.valid          = 1'b1;
    fill_done.set_way_offset = {addr[htu_pkg::ADDR_LO+htu_pkg::SET_W:htu_pkg::ADDR_LO+1],
                                way, addr[htu_pkg::ADDR_LO]};
    #SMP;
    check_bit("isu_valid_o", isu_valid, 1'b0);
    check_bit("linefill_valid_o", linefill_valid, 1'b0);
    @(posedge clk);
    #DRV;
    fill_done = '0;
    finish_test($sformatf("fill addr %h way %0d", addr, way));
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    int          rec;
    logic        done;
    logic [31:0] kind;
    rst        = 1'b1;
    xbar_valid = 1'b0;
    xbar_req   = '0;
    isu_allow  = 1'b0;
    fill_done  = '0;
    for (int i = 0; i < MAX_REC*REC_W; i++) begin
      pat_mem[i] = ~32'(i);
    end
    $readmemh("bench/htu_patterns.txt", pat_mem);

    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
    end
    #DRV;
    rst = 1'b0;

    rec  = 0;
    done = 1'b0;
    while (!done && !timed_out && rec < MAX_REC) begin
      kind      = pat_mem[rec*REC_W];
      cur_test  = rec + 1;
      test_errs = 0;
      if (kind == 32'd0) begin
        run_request(rec*REC_W);
      end else if (kind == 32'd1) begin
        run_fill(rec*REC_W);
      end else begin
        done = 1'b1;
      end
      rec++;
    end

    $display("tests %0d, failed %0d, mismatches %0d", test_count, fail_count, err_count);
    if (err_count == 0 && !timed_out && test_count > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/bank_htu.sv
`timescale 1ns/1ps
`default_nettype none

module bank_htu (
  input  wire                       clk_i,
  input  wire                       rst_i,
  // crossbar
  input  wire                       xbar_valid_i,
  input  wire htu_pkg::htu_req_t    xbar_req_i,
  output wire                       xbar_ready_o,
  // issue unit
  input  wire                       isu_allow_i,
  output wire                       isu_valid_o,
  output wire htu_pkg::isu_req_t    isu_req_o,
  output wire                       linefill_valid_o,
  output wire htu_pkg::linefill_t   linefill_o,
  input  wire htu_pkg::fill_done_t  fill_done_i
);

  wire htu_pkg::htu_lookup_t                         lookup;
  wire [htu_pkg::SET_W-1:0]                          set_idx;
  wire [htu_pkg::NUM_SETS-1:0]                       set_accept;
  wire htu_pkg::set_status_t [htu_pkg::NUM_SETS-1:0] set_status;

  // ready follows the issue unit's allow level
  assign xbar_ready_o = isu_allow_i;

  htu_req_decode u_req_decode (
    .clk_i        (clk_i       ),
    .xbar_valid_i (xbar_valid_i),
    .xbar_req_i   (xbar_req_i  ),
    .isu_allow_i  (isu_allow_i ),
    .lookup_o     (lookup      ),
    .set_idx_o    (set_idx     ),
    .set_accept_o (set_accept  )
  );

  // ----------------------------------------------------------
  // set array
  // ----------------------------------------------------------
  for (genvar g = 0; g < htu_pkg::NUM_SETS; g++) begin : g_set
    htu_set_entry #(
      .SET_ID (g)
    ) u_set_entry (
      .clk_i       (clk_i        ),
      .rst_i       (rst_i        ),
      .accept_i    (set_accept[g]),
      .lookup_i    (lookup       ),
      .fill_done_i (fill_done_i  ),
      .status_o    (set_status[g])
    );
  end

  htu_resp_mux u_resp_mux (
    .xbar_valid_i     (xbar_valid_i    ),
    .xbar_req_i       (xbar_req_i      ),
    .lookup_i         (lookup          ),
    .set_idx_i        (set_idx         ),
    .status_i         (set_status      ),
    .isu_valid_o      (isu_valid_o     ),
    .isu_req_o        (isu_req_o       ),
    .linefill_valid_o (linefill_valid_o),
    .linefill_o       (linefill_o      )
  );

endmodule

`default_nettype wire

// File: hdl/htu_pkg.sv
`default_nettype none

package htu_pkg;

  // bank geometry
  localparam int NUM_SETS = 8;
  localparam int NUM_WAYS = 8;
  localparam int SET_W    = 3;
  localparam int WAY_W    = 3;
  localparam int TAG_W    = 22;
  localparam int ADDR_LO  = 4;

  // crossbar opcodes without flush and invalidate
  localparam logic [1:0] OP_READ  = 2'b00;
  localparam logic [1:0] OP_WRITE = 2'b01;

  // per-offset line state
  localparam logic [1:0] ST_EMPTY = 2'b00;
  localparam logic [1:0] ST_CLEAN = 2'b01;
  localparam logic [1:0] ST_DIRTY = 2'b11;

  typedef struct packed {
    logic [1:0]        ch_id;
    logic [1:0]        opcode;
    logic [31:ADDR_LO] addr;
    logic [7:0]        wbuffer_id;
  } htu_req_t;

  typedef struct packed {
    logic             is_read;
    logic             is_write;
    logic [TAG_W-1:0] tag;
    logic             offset;
  } htu_lookup_t;

  typedef struct packed {
    logic             hit;
    logic             need_evict;
    logic [WAY_W-1:0] way;
    logic [1:0]       off0_state;
    logic [1:0]       off1_state;
  } set_status_t;

  typedef struct packed {
    logic [SET_W-1:0] set;
    logic [WAY_W-1:0] way;
  } linefill_t;

  // opcode bit 0 is write, bit 1 is need-evict
  typedef struct packed {
    logic [1:0]               ch_id;
    logic [1:0]               opcode;
    logic [SET_W+WAY_W:0]     set_way_offset;
    logic [7:0]               wbuffer_id;
    logic [1:0]               off0_state;
    logic [1:0]               off1_state;
  } isu_req_t;

  typedef struct packed {
    logic                 valid;
    logic [SET_W+WAY_W:0] set_way_offset;
  } fill_done_t;

endpackage

`default_nettype wire

// File: hdl/htu_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module htu_req_decode (
  input  wire                               clk_i,
  input  wire                               xbar_valid_i,
  input  wire htu_pkg::htu_req_t            xbar_req_i,
  input  wire                               isu_allow_i,
  output htu_pkg::htu_lookup_t              lookup_o,
  output logic [htu_pkg::SET_W-1:0]         set_idx_o,
  output logic [htu_pkg::NUM_SETS-1:0]      set_accept_o
);

  logic [htu_pkg::NUM_SETS-1:0] set_onehot;
  logic                         xfer;

  // ----------------------------------------------------------
  // address split into tag, index and offset
  // ----------------------------------------------------------
  always_comb begin
    lookup_o.is_read  = xbar_req_i.opcode == htu_pkg::OP_READ;
    lookup_o.is_write = xbar_req_i.opcode == htu_pkg::OP_WRITE;
    lookup_o.tag      = xbar_req_i.addr[31:32-htu_pkg::TAG_W];
    lookup_o.offset   = xbar_req_i.addr[htu_pkg::ADDR_LO];
  end

  assign set_idx_o =
    xbar_req_i.addr[htu_pkg::ADDR_LO+htu_pkg::SET_W:htu_pkg::ADDR_LO+1];

  always_comb begin
    set_onehot            = '0;
    set_onehot[set_idx_o] = 1'b1;
  end

  // only the indexed set sees the strobe
  assign xfer         = xbar_valid_i & isu_allow_i;
  assign set_accept_o = {htu_pkg::NUM_SETS{xfer}} & set_onehot;

  // crossbar must hold a stalled request
  a_req_stable: assert property (
    @(posedge clk_i)
    xbar_valid_i && !isu_allow_i |=> xbar_valid_i && $stable(xbar_req_i)
  ) else $error("request changed while stalled");

endmodule

`default_nettype wire

// File: hdl/htu_resp_mux.sv
`timescale 1ns/1ps
`default_nettype none

module htu_resp_mux (
  input  wire                                                xbar_valid_i,
  input  wire htu_pkg::htu_req_t                             xbar_req_i,
  input  wire htu_pkg::htu_lookup_t                          lookup_i,
  input  wire [htu_pkg::SET_W-1:0]                           set_idx_i,
  input  wire htu_pkg::set_status_t [htu_pkg::NUM_SETS-1:0]  status_i,
  output logic                                               isu_valid_o,
  output htu_pkg::isu_req_t                                  isu_req_o,
  output logic                                               linefill_valid_o,
  output htu_pkg::linefill_t                                 linefill_o
);

  htu_pkg::set_status_t sel;
  logic [1:0]           access_state;
  logic                 need_fill;

  // ----------------------------------------------------------
  // indexed set select
  // ----------------------------------------------------------
  assign sel = status_i[set_idx_i];

  assign access_state = lookup_i.offset ? sel.off1_state : sel.off0_state;

  // miss, or hit on an offset not yet filled
  assign need_fill = !sel.hit || (access_state == htu_pkg::ST_EMPTY);

  // ----------------------------------------------------------
  // linefill request
  // ----------------------------------------------------------
  assign linefill_valid_o = xbar_valid_i && lookup_i.is_read && need_fill;

  always_comb begin
    linefill_o.set = set_idx_i;
    linefill_o.way = sel.way;
  end

  // ----------------------------------------------------------
  // issue unit request
  // ----------------------------------------------------------
  assign isu_valid_o = xbar_valid_i;

  always_comb begin
    isu_req_o.ch_id          = xbar_req_i.ch_id;
    isu_req_o.opcode         = {sel.need_evict, lookup_i.is_write};
    isu_req_o.set_way_offset = {set_idx_i, sel.way, lookup_i.offset};
    isu_req_o.wbuffer_id     = xbar_req_i.wbuffer_id;
    isu_req_o.off0_state     = sel.off0_state;
    isu_req_o.off1_state     = sel.off1_state;
  end

endmodule

`default_nettype wire

// File: hdl/htu_set_entry.sv
`timescale 1ns/1ps
`default_nettype none

module htu_set_entry #(
  parameter int SET_ID = 0
) (
  input  wire                         clk_i,
  input  wire                         rst_i,
  input  wire                         accept_i,
  input  wire htu_pkg::htu_lookup_t   lookup_i,
  input  wire htu_pkg::fill_done_t    fill_done_i,
  output htu_pkg::set_status_t        status_o
);

  logic [htu_pkg::NUM_WAYS-1:0] way_valid;
  logic [htu_pkg::TAG_W-1:0]    way_tag [htu_pkg::NUM_WAYS];
  logic [1:0]                   off0_st [htu_pkg::NUM_WAYS];
  logic [1:0]                   off1_st [htu_pkg::NUM_WAYS];
  logic [htu_pkg::WAY_W-1:0]    victim_ptr;

  logic [htu_pkg::NUM_WAYS-1:0] hit_vec;
  logic                         hit;
  logic [htu_pkg::WAY_W-1:0]    hit_way;
  logic [htu_pkg::WAY_W-1:0]    access_way;
  logic                         victim_dirty;

  logic [htu_pkg::SET_W-1:0]    fill_set;
  logic [htu_pkg::WAY_W-1:0]    fill_way;
  logic                         fill_off;
  logic                         fill_here;

  // ----------------------------------------------------------
  // tag compare
  // ----------------------------------------------------------
  always_comb begin
    for (int w = 0; w < htu_pkg::NUM_WAYS; w++) begin
      hit_vec[w] = way_valid[w] && (way_tag[w] == lookup_i.tag);
    end
  end

  assign hit = |hit_vec;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < htu_pkg::NUM_WAYS; w++) begin
      if (hit_vec[w]) begin
        hit_way = htu_pkg::WAY_W'(w);
      end
    end
  end

  // miss goes to the round-robin victim
  assign access_way = hit ? hit_way : victim_ptr;

  assign victim_dirty = (off0_st[victim_ptr] == htu_pkg::ST_DIRTY) ||
                        (off1_st[victim_ptr] == htu_pkg::ST_DIRTY);

  always_comb begin
    status_o.hit        = hit;
    status_o.need_evict = !hit && way_valid[victim_ptr] && victim_dirty;
    status_o.way        = access_way;
    status_o.off0_state = off0_st[access_way];
    status_o.off1_state = off1_st[access_way];
  end

  // ----------------------------------------------------------
  // fill completion from issue unit
  // ----------------------------------------------------------
  assign fill_set  = fill_done_i.set_way_offset[htu_pkg::SET_W+htu_pkg::WAY_W:
                                                htu_pkg::WAY_W+1];
  assign fill_way  = fill_done_i.set_way_offset[htu_pkg::WAY_W:1];
  assign fill_off  = fill_done_i.set_way_offset[0];
  assign fill_here = fill_done_i.valid && (fill_set == htu_pkg::SET_W'(SET_ID));

  // ----------------------------------------------------------
  // state update
  // ----------------------------------------------------------
  // install and write override a same-cycle fill
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      way_valid  <= '0;
      victim_ptr <= '0;
      for (int w = 0; w < htu_pkg::NUM_WAYS; w++) begin
        off0_st[w] <= htu_pkg::ST_EMPTY;
        off1_st[w] <= htu_pkg::ST_EMPTY;
      end
    end else begin
      if (fill_here) begin
        if (fill_off) begin
          off1_st[fill_way] <= htu_pkg::ST_CLEAN;
        end else begin
          off0_st[fill_way] <= htu_pkg::ST_CLEAN;
        end
      end
      if (accept_i) begin
        if (!hit) begin
          way_valid[victim_ptr] <= 1'b1;
          off0_st[victim_ptr]   <= htu_pkg::ST_EMPTY;
          off1_st[victim_ptr]   <= htu_pkg::ST_EMPTY;
          victim_ptr            <= victim_ptr + 1'b1;
        end
        if (lookup_i.is_write) begin
          if (lookup_i.offset) begin
            off1_st[access_way] <= htu_pkg::ST_DIRTY;
          end else begin
            off0_st[access_way] <= htu_pkg::ST_DIRTY;
          end
        end
      end
    end
  end

  // tag array
  always_ff @(posedge clk_i) begin
    if (accept_i && !hit) begin
      way_tag[victim_ptr] <= lookup_i.tag;
    end
  end

  // install never duplicates a resident tag
  a_single_hit: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $onehot0(hit_vec)
  ) else $error("set %0d: multiple ways hit", SET_ID);

endmodule

`default_nettype wire

// File: run_bank_htu.sh
#!/usr/bin/env bash
# build and run the bank hit-test unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim_bank_htu.log

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_bank_htu \
  -f bank_htu.f \
  -o Vtb_bank_htu

./obj_dir/Vtb_bank_htu | tee "$LOG"

if grep -q "Regression passed" "$LOG"; then
  exit 0
else
  echo "simulation did not pass, see $LOG"
  exit 1
fi
